// ==== design/cas_arb_settings.svh ====
/*
  Sizing for the CAS arbiter.
  The pair tree is fixed at four groups in two pairs.
  Changing the group count needs a new winner stage.
*/
`ifndef CAS_ARB_SETTINGS_SVH
`define CAS_ARB_SETTINGS_SVH

// ------------------------------
// Requester count
// ------------------------------
// Bank-group machines that present column requests
`define CAS_ARB_NUM_GROUPS 4

// Pairs in the first arbitration level
`define CAS_ARB_NUM_PAIRS (`CAS_ARB_NUM_GROUPS / 2)

// ------------------------------
// Address field widths
// ------------------------------
// Rank select, also used for precharge blocking
`define CAS_ARB_RANK_BITS 2
// Bank within a bank group
`define CAS_ARB_BANK_BITS 2
// Bank group
`define CAS_ARB_BG_BITS 2

`endif

// ==== design/cas_arb_pkg.sv ====
/*
  Shared types for the CAS arbiter.
  Field arrays are packed with group 0 in the low slice.
*/
`include "cas_arb_settings.svh"

package cas_arb_pkg;

  // One bit per requester and its index
  typedef logic [`CAS_ARB_NUM_GROUPS-1:0] group_vec_t;
  typedef logic [$clog2(`CAS_ARB_NUM_GROUPS)-1:0] group_idx_t;
  // One bit per member of a pair
  typedef logic [1:0] pair_vec_t;

  // Address fields
  typedef logic [`CAS_ARB_RANK_BITS-1:0] rank_t;
  typedef logic [`CAS_ARB_BANK_BITS-1:0] bank_t;
  typedef logic [`CAS_ARB_BG_BITS-1:0] bgroup_t;
  typedef rank_t [`CAS_ARB_NUM_GROUPS-1:0] rank_arr_t;
  typedef bank_t [`CAS_ARB_NUM_GROUPS-1:0] bank_arr_t;
  typedef bgroup_t [`CAS_ARB_NUM_GROUPS-1:0] bgroup_arr_t;

  // Winner opcode
  typedef enum logic [1:0] {
    CAS_NONE  = 2'd0,
    CAS_READ  = 2'd1,
    CAS_WRITE = 2'd2
  } cas_op_e;

  // Two-way round robin pick, upper member wins a tie unless it won last
  function automatic pair_vec_t pair_pick(input logic last, input pair_vec_t req);
    pair_vec_t pick;
    case (req)
      2'b01:   pick = 2'b01;
      2'b10:   pick = 2'b10;
      2'b11:   pick = last ? 2'b01 : 2'b10;
      default: pick = 2'b00;
    endcase
    return pick;
  endfunction

endpackage

// ==== design/cas_cand_if.sv ====
/*
  Qualified CAS candidates between qualifier and winner stage.
  Purely combinational, no clock inside.
*/
`timescale 1ns/1ps

interface cas_cand_if;
  import cas_arb_pkg::*;

  // Requests left after precharge rank masking
  group_vec_t rd_ok;
  group_vec_t wr_ok;

  // Address fields per group, unchanged from the inputs
  bank_arr_t   bank;
  bgroup_arr_t bgroup;
  rank_arr_t   rank;

  // Qualifier side
  modport src (
    output rd_ok,
    output wr_ok,
    output bank,
    output bgroup,
    output rank
  );

  // Winner stage side
  modport snk (
    input rd_ok,
    input wr_ok,
    input bank,
    input bgroup,
    input rank
  );

endinterface

// ==== design/cas_req_qualify.sv ====
/*
  Request qualifier for the CAS arbiter.
  A group must not present a read and a write together.
  Any pending precharge blocks every group on the same rank.
*/
`timescale 1ns/1ps
`include "cas_arb_settings.svh"

module cas_req_qualify (
  input  cas_arb_pkg::group_vec_t  cas_rd,
  input  cas_arb_pkg::group_vec_t  cas_wr,
  input  cas_arb_pkg::group_vec_t  pre_req,
  input  cas_arb_pkg::rank_arr_t   cas_rank,
  input  cas_arb_pkg::rank_arr_t   pre_rank,
  input  cas_arb_pkg::bank_arr_t   cas_bank,
  input  cas_arb_pkg::bgroup_arr_t cas_bgroup,
  cas_cand_if.src                  cand,
  output cas_arb_pkg::group_vec_t  req
);
  import cas_arb_pkg::*;

  // One bit per rank value
  logic [(1 << `CAS_ARB_RANK_BITS)-1:0] blocked;
  group_vec_t rd_ok;
  group_vec_t wr_ok;

  // ------------------------------
  // Precharge rank blocking
  // ------------------------------
  always_comb begin
    blocked = '0;
    for (int g = 0; g < `CAS_ARB_NUM_GROUPS; g++) begin
      // Any group waiting to precharge claims its rank
      if (pre_req[g]) begin
        blocked[pre_rank[g]] = 1'b1;
      end
    end
  end

  // Drop reads and writes that target a blocked rank
  always_comb begin
    for (int g = 0; g < `CAS_ARB_NUM_GROUPS; g++) begin
      rd_ok[g] = cas_rd[g] & ~blocked[cas_rank[g]];
      wr_ok[g] = cas_wr[g] & ~blocked[cas_rank[g]];
    end
  end

  // ------------------------------
  // Read priority
  // ------------------------------
  // Writes only compete when no unmasked read is left
  assign req = (|rd_ok) ? rd_ok : wr_ok;

  // Candidates for the winner stage
  assign cand.rd_ok  = rd_ok;
  assign cand.wr_ok  = wr_ok;
  // Address fields pass straight through
  assign cand.bank   = cas_bank;
  assign cand.bgroup = cas_bgroup;
  assign cand.rank   = cas_rank;

endmodule

// ==== design/cas_pair_arb.sv ====
/*
  Round robin between two neighbouring bank groups.
  Pick is one-hot or zero and purely combinational.
  The fairness bit moves only on a grant from the winner stage.
*/
`timescale 1ns/1ps

module cas_pair_arb (
  input  logic                   clk,
  input  logic                   rst,
  input  cas_arb_pkg::pair_vec_t req,
  input  logic                   grant,
  output cas_arb_pkg::pair_vec_t pick
);
  import cas_arb_pkg::*;

  // Set when the upper member won the last grant
  logic last_hi;

  // ------------------------------
  // Member choice
  // ------------------------------
  // A single requester always wins
  // On a tie the member that did not win last goes
  assign pick = pair_pick(last_hi, req);

  // ------------------------------
  // Fairness state
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!rst) begin
      last_hi <= 1'b0;
    end else if (grant) begin
      // Grant implies a nonzero pick
      // Remember which member went out
      last_hi <= pick[1];
    end
  end

  // Back-pressure holds last_hi as is
  // So a stalled pair keeps its turn order

endmodule

// ==== design/cas_win_select.sv ====
/*
  Final stage of the CAS arbiter.
  Chooses between the two pair picks, grants the chosen pair
  and registers the winner while tran_sent is high.
  With no candidate on tran_sent the outputs clear.
*/
`timescale 1ns/1ps
`include "cas_arb_settings.svh"

module cas_win_select (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          tran_sent,
  input  cas_arb_pkg::pair_vec_t        pick_lo,
  input  cas_arb_pkg::pair_vec_t        pick_hi,
  cas_cand_if.snk                       cand,
  output logic [`CAS_ARB_NUM_PAIRS-1:0] grant,
  output cas_arb_pkg::group_vec_t       win_port,
  output cas_arb_pkg::group_idx_t       win_port_enc,
  output cas_arb_pkg::cas_op_e          win_op,
  output cas_arb_pkg::bank_t            win_bank,
  output cas_arb_pkg::bgroup_t          win_bgroup,
  output cas_arb_pkg::rank_t            win_rank
);
  import cas_arb_pkg::*;

  // Set when groups 2 or 3 won last
  logic       last_upper;
  pair_vec_t  pair_req;
  pair_vec_t  pair_sel;
  group_vec_t win_vec;
  group_idx_t win_idx;
  logic       win_any;
  cas_op_e    win_op_nxt;

  // ------------------------------
  // Pair to pair choice
  // ------------------------------
  assign pair_req = {|pick_hi, |pick_lo};
  // Upper pair wins a tie unless it went last
  assign pair_sel = pair_pick(last_upper, pair_req);
  assign win_any  = |pair_sel;

  // One-hot winner over all groups
  assign win_vec = {pair_sel[1] ? pick_hi : 2'b00,
                    pair_sel[0] ? pick_lo : 2'b00};

  // High bit is the pair, low bit the member inside it
  assign win_idx = {pair_sel[1], pair_sel[1] ? pick_hi[1] : pick_lo[1]};

  // Pair state only moves when the command really goes out
  assign grant = tran_sent ? pair_sel : '0;

  // Opcode of the winning group
  always_comb begin
    if (cand.rd_ok[win_idx]) begin
      win_op_nxt = CAS_READ;
    end else if (cand.wr_ok[win_idx]) begin
      win_op_nxt = CAS_WRITE;
    end else begin
      win_op_nxt = CAS_NONE;
    end
  end

  // ------------------------------
  // Winner registers
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!rst) begin
      last_upper   <= 1'b0;
      win_port     <= '0;
      win_port_enc <= '0;
      win_op       <= CAS_NONE;
      win_bank     <= '0;
      win_bgroup   <= '0;
      win_rank     <= '0;
    end else if (tran_sent) begin
      if (win_any) begin
        last_upper   <= win_idx[1];
        win_port     <= win_vec;
        win_port_enc <= win_idx;
        win_op       <= win_op_nxt;
        win_bank     <= cand.bank[win_idx];
        win_bgroup   <= cand.bgroup[win_idx];
        win_rank     <= cand.rank[win_idx];
      end else begin
        // Nothing eligible, present an idle slot
        win_port     <= '0;
        win_port_enc <= '0;
        win_op       <= CAS_NONE;
        win_bank     <= '0;
        win_bgroup   <= '0;
        win_rank     <= '0;
      end
    end
  end

endmodule

// ==== design/cas_arbiter.sv ====
/*
  CAS arbiter top level for four bank-group machines.
  Reads beat writes, precharge blocks a whole rank.
  Winner outputs load one cycle after an edge with tran_sent high.
*/
`timescale 1ns/1ps
`include "cas_arb_settings.svh"

module cas_arbiter (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     tran_sent,
  // Per group request levels
  input  cas_arb_pkg::group_vec_t  cas_rd,
  input  cas_arb_pkg::group_vec_t  cas_wr,
  input  cas_arb_pkg::group_vec_t  pre_req,
  // Per group address fields
  input  cas_arb_pkg::rank_arr_t   cas_rank,
  input  cas_arb_pkg::rank_arr_t   pre_rank,
  input  cas_arb_pkg::bank_arr_t   cas_bank,
  input  cas_arb_pkg::bgroup_arr_t cas_bgroup,
  // Registered winner
  output cas_arb_pkg::group_vec_t  win_port,
  output cas_arb_pkg::group_idx_t  win_port_enc,
  output cas_arb_pkg::cas_op_e     win_op,
  output cas_arb_pkg::bank_t       win_bank,
  output cas_arb_pkg::bgroup_t     win_bgroup,
  output cas_arb_pkg::rank_t       win_rank
);
  import cas_arb_pkg::*;

  group_vec_t                   req;
  pair_vec_t                    picks [`CAS_ARB_NUM_PAIRS];
  logic [`CAS_ARB_NUM_PAIRS-1:0] grant;

  cas_cand_if cand_if ();

  // Masking and read priority
  cas_req_qualify req_qualify_inst (
    .cas_rd     (cas_rd),
    .cas_wr     (cas_wr),
    .pre_req    (pre_req),
    .cas_rank   (cas_rank),
    .pre_rank   (pre_rank),
    .cas_bank   (cas_bank),
    .cas_bgroup (cas_bgroup),
    .cand       (cand_if),
    .req        (req)
  );

  // ------------------------------
  // First level, groups 0/1 and 2/3
  // ------------------------------
  for (genvar p = 0; p < `CAS_ARB_NUM_PAIRS; p++) begin : g_pair
    cas_pair_arb pair_arb_inst (
      .clk   (clk),
      .rst   (rst),
      .req   (req[2*p +: 2]),
      .grant (grant[p]),
      .pick  (picks[p])
    );
  end

  // Final choice and output registers
  cas_win_select win_select_inst (
    .clk          (clk),
    .rst          (rst),
    .tran_sent    (tran_sent),
    .pick_lo      (picks[0]),
    .pick_hi      (picks[1]),
    .cand         (cand_if),
    .grant        (grant),
    .win_port     (win_port),
    .win_port_enc (win_port_enc),
    .win_op       (win_op),
    .win_bank     (win_bank),
    .win_bgroup   (win_bgroup),
    .win_rank     (win_rank)
  );

endmodule

// ==== verification/cas_arb_clk_gen.sv ====
/*
  Clock and reset source for the CAS arbiter testbench.
  10 ns period, reset held low for the first 4 rising edges.
*/
`timescale 1ns/1ps

module cas_arb_clk_gen (
  output logic clk,
  output logic rst
);

  // Free running clock
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Active low reset, released on a rising edge
  initial begin
    rst = 1'b0;
    repeat (4) @(posedge clk);
    rst <= 1'b1;
  end

endmodule

// ==== verification/cas_arb_chk.sv ====
/*
  Concurrent assertions on the CAS arbiter top level.
  Only active while reset is released.
*/
`timescale 1ns/1ps

module cas_arb_chk (
  input logic                    clk,
  input logic                    rst,
  input logic                    tran_sent,
  input cas_arb_pkg::group_vec_t cas_rd,
  input cas_arb_pkg::group_vec_t cas_wr,
  input cas_arb_pkg::group_vec_t win_port,
  input cas_arb_pkg::group_idx_t win_port_enc,
  input cas_arb_pkg::cas_op_e    win_op,
  input cas_arb_pkg::bank_t      win_bank,
  input cas_arb_pkg::bgroup_t    win_bgroup,
  input cas_arb_pkg::rank_t      win_rank
);
  import cas_arb_pkg::*;

  // At most one winning group
  a_port_onehot: assert property (@(posedge clk) disable iff (!rst)
    $onehot0(win_port))
    else $error("win_port has more than one bit set");

  // Idle opcode exactly when no port is granted
  a_op_idle: assert property (@(posedge clk) disable iff (!rst)
    (win_op == CAS_NONE) == (win_port == '0))
    else $error("win_op does not match an empty win_port");

  // Back-pressure freezes every winner output
  a_hold: assert property (@(posedge clk) disable iff (!rst)
    !tran_sent |=> $stable(win_port) && $stable(win_port_enc) && $stable(win_op)
      && $stable(win_bank) && $stable(win_bgroup) && $stable(win_rank))
    else $error("winner outputs moved while tran_sent was low");

  // Input rule, a group never reads and writes together
  a_rd_wr: assert property (@(posedge clk) disable iff (!rst)
    (cas_rd & cas_wr) == '0)
    else $error("a group presents a read and a write at once");

endmodule

// ------------------------------
// Attach to the arbiter
// ------------------------------
bind cas_arbiter cas_arb_chk chk_inst (
  .clk (clk), .rst (rst), .tran_sent (tran_sent), .cas_rd (cas_rd), .cas_wr (cas_wr),
  .win_port (win_port), .win_port_enc (win_port_enc), .win_op (win_op),
  .win_bank (win_bank), .win_bgroup (win_bgroup), .win_rank (win_rank)
);

// ==== verification/cas_arb_tb.sv ====
/*
  Directed testbench for the CAS arbiter.
  Each request step pulses tran_sent for one edge and checks a cycle later.
  The fixed rotation check needs the round robin test first after reset.
*/
`timescale 1ns/1ps
`include "cas_arb_settings.svh"

module cas_arb_tb;
  import cas_arb_pkg::*;

  // 35 steps of two cycles plus reset and slack
  localparam int TEST_CYCLES = 76;

  logic        clk;
  logic        rst;
  logic        tran_sent;
  group_vec_t  cas_rd;
  group_vec_t  cas_wr;
  group_vec_t  pre_req;
  rank_arr_t   cas_rank;
  rank_arr_t   pre_rank;
  bank_arr_t   cas_bank;
  bgroup_arr_t cas_bgroup;
  group_vec_t  win_port;
  group_idx_t  win_port_enc;
  cas_op_e     win_op;
  bank_t       win_bank;
  bgroup_t     win_bgroup;
  rank_t       win_rank;

  // Expected winner starts at the reset values
  group_vec_t exp_port   = '0;
  group_idx_t exp_enc    = '0;
  cas_op_e    exp_op     = CAS_NONE;
  bank_t      exp_bank   = '0;
  bgroup_t    exp_bgroup = '0;
  rank_t      exp_rank   = '0;
  // Model fairness state
  logic [1:0] m_last_hi    = '0;
  logic       m_last_upper = 1'b0;

  integer seed;
  int     errors = 0;
  int     checks = 0;

  cas_arb_clk_gen clk_gen_inst (
    .clk (clk),
    .rst (rst)
  );

  cas_arbiter cas_arbiter_inst (
    .clk (clk), .rst (rst), .tran_sent (tran_sent),
    .cas_rd (cas_rd), .cas_wr (cas_wr), .pre_req (pre_req),
    .cas_rank (cas_rank), .pre_rank (pre_rank),
    .cas_bank (cas_bank), .cas_bgroup (cas_bgroup),
    .win_port (win_port), .win_port_enc (win_port_enc), .win_op (win_op),
    .win_bank (win_bank), .win_bgroup (win_bgroup), .win_rank (win_rank)
  );

  // ------------------------------
  // Compare tasks
  // ------------------------------
  task automatic compare_vec(input string name, input group_vec_t got, input group_vec_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic compare_idx(input string name, input group_idx_t got, input group_idx_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic compare_op(input string name, input cas_op_e got, input cas_op_e exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t %s got %s expected %s", $time, name, got.name(), exp.name());
    end
  endtask

  task automatic compare_bank(input string name, input bank_t got, input bank_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic compare_bgroup(input string name, input bgroup_t got, input bgroup_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic compare_rank(input string name, input rank_t got, input rank_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic verify_outputs();
    compare_vec("win_port", win_port, exp_port);
    compare_idx("win_port_enc", win_port_enc, exp_enc);
    compare_op("win_op", win_op, exp_op);
    compare_bank("win_bank", win_bank, exp_bank);
    compare_bgroup("win_bgroup", win_bgroup, exp_bgroup);
    compare_rank("win_rank", win_rank, exp_rank);
  endtask

  // ------------------------------
  // Reference model
  // ------------------------------
  // Returns the winning group or -1
  // is_rd tells whether reads or writes competed
  function automatic int model_winner(input group_vec_t rd, input group_vec_t wr,
      input group_vec_t pre, input rank_arr_t rank, input rank_arr_t prank,
      output logic is_rd);
    logic       masked;
    group_vec_t rd_ok;
    group_vec_t wr_ok;
    group_vec_t req;
    int member [2];
    int pair;
    // A request drops out when any pending precharge names its rank
    for (int g = 0; g < `CAS_ARB_NUM_GROUPS; g++) begin
      masked = 1'b0;
      for (int h = 0; h < `CAS_ARB_NUM_GROUPS; h++) begin
        if (pre[h] && prank[h] == rank[g]) begin
          masked = 1'b1;
        end
      end
      rd_ok[g] = rd[g] && !masked;
      wr_ok[g] = wr[g] && !masked;
    end
    is_rd = (rd_ok != '0);
    req = is_rd ? rd_ok : wr_ok;
    // Pair level picks the upper member unless it went last
    for (int p = 0; p < 2; p++) begin
      if (req[2*p] && req[2*p+1]) begin
        member[p] = m_last_hi[p] ? 0 : 1;
      end else if (req[2*p+1]) begin
        member[p] = 1;
      end else if (req[2*p]) begin
        member[p] = 0;
      end else begin
        member[p] = -1;
      end
    end
    // Groups 2/3 beat groups 0/1 unless they went last
    if (member[0] >= 0 && member[1] >= 0) begin
      pair = m_last_upper ? 0 : 1;
    end else if (member[1] >= 0) begin
      pair = 1;
    end else if (member[0] >= 0) begin
      pair = 0;
    end else begin
      pair = -1;
    end
    if (pair < 0) begin
      return -1;
    end
    return 2 * pair + member[pair];
  endfunction

  // Drive one request set for the next edge and check the winner after it
  task automatic issue_request(input group_vec_t rd, input group_vec_t wr,
      input group_vec_t pre, input rank_arr_t rank, input rank_arr_t prank, input logic ts);
    logic [31:0] rnd;
    bank_arr_t   bank_v;
    bgroup_arr_t bgroup_v;
    int          win;
    logic        is_rd;
    rnd = $random(seed);
    bank_v = rnd[7:0];
    bgroup_v = rnd[15:8];
    @(posedge clk);
    cas_rd <= rd;
    cas_wr <= wr;
    pre_req <= pre;
    cas_rank <= rank;
    pre_rank <= prank;
    cas_bank <= bank_v;
    cas_bgroup <= bgroup_v;
    tran_sent <= ts;
    @(posedge clk);
    tran_sent <= 1'b0;
    if (ts) begin
      win = model_winner(rd, wr, pre, rank, prank, is_rd);
      exp_port = '0;
      if (win < 0) begin
        exp_enc = '0;
        exp_op = CAS_NONE;
        exp_bank = '0;
        exp_bgroup = '0;
        exp_rank = '0;
      end else begin
        exp_port[win] = 1'b1;
        exp_enc = win[1:0];
        exp_op = is_rd ? CAS_READ : CAS_WRITE;
        exp_bank = bank_v[win];
        exp_bgroup = bgroup_v[win];
        exp_rank = rank[win];
        m_last_hi[win[1]] = win[0];
        m_last_upper = win[1];
      end
    end
    @(negedge clk);
    verify_outputs();
  endtask

  // ------------------------------
  // Directed tests
  // ------------------------------
  task automatic test_reset();
    wait (rst === 1'b1);
    @(negedge clk);
    verify_outputs();
  endtask

  task automatic test_round_robin();
    group_idx_t  order [4];
    logic [31:0] rnd;
    order = '{2'd3, 2'd1, 2'd2, 2'd0};
    for (int i = 0; i < 8; i++) begin
      issue_request(4'b1111, '0, '0, 8'h00, 8'h00, 1'b1);
      compare_idx("win_port_enc rotation", win_port_enc, order[i[1:0]]);
    end
    // Random subsets with reads and writes kept apart
    for (int i = 0; i < 6; i++) begin
      rnd = $random(seed);
      issue_request(rnd[3:0], rnd[7:4] & ~rnd[3:0], '0, rnd[15:8], '0, 1'b1);
    end
  endtask

  task automatic test_single();
    logic [31:0] rnd;
    group_vec_t  one;
    for (int g = 0; g < `CAS_ARB_NUM_GROUPS; g++) begin
      one = '0;
      one[g] = 1'b1;
      rnd = $random(seed);
      issue_request(one, '0, '0, rnd[7:0], '0, 1'b1);
      issue_request('0, one, '0, rnd[15:8], '0, 1'b1);
    end
  endtask

  task automatic test_read_prio();
    issue_request(4'b0100, 4'b1011, '0, 8'h00, 8'h00, 1'b1);
    compare_vec("win_port read first", win_port, 4'b0100);
    issue_request(4'b0001, 4'b1110, '0, 8'h00, 8'h00, 1'b1);
    compare_vec("win_port read first", win_port, 4'b0001);
    issue_request('0, 4'b0110, '0, 8'h00, 8'h00, 1'b1);
    compare_op("win_op writes only", win_op, CAS_WRITE);
    // Read on rank 1 blocked by a precharge from group 3
    issue_request(4'b0001, 4'b0100, 4'b1000, 8'b00_00_00_01, 8'b01_00_00_00, 1'b1);
    compare_vec("win_port masked read", win_port, 4'b0100);
  endtask

  task automatic test_masking();
    // Group g sits on rank g
    issue_request(4'b1111, '0, 4'b0001, 8'b11_10_01_00, 8'b00_00_00_11, 1'b1);
    issue_request(4'b1000, 4'b0010, 4'b0001, 8'b11_10_01_00, 8'b00_00_00_11, 1'b1);
    compare_vec("win_port masked read", win_port, 4'b0010);
    issue_request(4'b1111, '0, 4'b1111, 8'b11_10_01_00, 8'b11_10_01_00, 1'b1);
    compare_op("win_op all blocked", win_op, CAS_NONE);
  endtask

  task automatic test_backpressure();
    logic [31:0] rnd;
    issue_request(4'b1111, '0, '0, 8'h00, 8'h00, 1'b1);
    for (int i = 0; i < 4; i++) begin
      rnd = $random(seed);
      issue_request(rnd[3:0], rnd[7:4] & ~rnd[3:0], '0, rnd[15:8], '0, 1'b0);
    end
    issue_request(4'b1111, '0, '0, 8'h00, 8'h00, 1'b1);
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    seed = 32'hec3bb8de;
    tran_sent <= 1'b0;
    cas_rd <= '0;
    cas_wr <= '0;
    pre_req <= '0;
    cas_rank <= '0;
    pre_rank <= '0;
    cas_bank <= '0;
    cas_bgroup <= '0;
    test_reset();
    test_round_robin();
    test_single();
    test_read_prio();
    test_masking();
    test_backpressure();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Watchdog with a wide margin over the test length
  initial begin
    #(200 * TEST_CYCLES * 10);
    $display("Timeout, the tests did not finish within %0d cycles", 200 * TEST_CYCLES);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+design
design/cas_arb_pkg.sv
design/cas_cand_if.sv
design/cas_req_qualify.sv
design/cas_pair_arb.sv
design/cas_win_select.sv
design/cas_arbiter.sv
verification/cas_arb_clk_gen.sv
verification/cas_arb_chk.sv
verification/cas_arb_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the CAS arbiter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module cas_arb_tb -o cas_arb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/cas_arb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qF "*** TEST PASSED ***" sim.log; then
  echo "Result: pass"
  exit 0
fi

echo "Result: fail"
exit 1
